/* Makefile */
# Verilator simulation of the FC core testbench

TOP := fc_core_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir $(OBJ)

# Passes only when the simulation prints the pass message
run: compile
	@out="$$(./$(OBJ)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ)

/* project.f */
+incdir+include
rtl/fc_num_pkg.sv
rtl/fc_beat_pkg.sv
rtl/fc_beat_decode.sv
rtl/mac_lane.sv
rtl/fc_mac_array.sv
rtl/fc_result.sv
rtl/fc_core.sv
sim/fc_core_tb.sv

/* rtl/fc_beat_decode.sv */
`timescale 1ns/1ps
/*
  Registers one beat per valid cycle and splits each lane into sign and magnitudes.
  The bias is only taken on a beat whose last flag is set.
*/
module fc_beat_decode (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    in_valid,
  input  fc_beat_pkg::fc_beat_t   in_beat,
  input  fc_beat_pkg::bias_vec_t  in_bias,
  output fc_beat_pkg::dec_beat_t  dec,
  output fc_beat_pkg::bias_vec_t  dec_bias
);
  import fc_num_pkg::*;
  import fc_beat_pkg::*;

  logic                   vld_q;
  logic                   first_q;
  logic                   last_q;
  lane_op_t [LANES-1:0]   ops_q;

  // Weights go through here too, they share the byte format
  function automatic mag_t magnitude(act_t v);
    return v[7] ? mag_t'(~v + 8'sd1) : mag_t'(v);
  endfunction

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      first_q <= in_beat.first;
      last_q  <= in_beat.last;
      for (int i = 0; i < LANES; i++) begin
        // A zero operand with a negative sign still yields zero after negation
        ops_q[i].sign  <= in_beat.feature[7] ^ in_beat.weights[i][7];
        ops_q[i].a_mag <= magnitude(in_beat.feature);
        ops_q[i].b_mag <= magnitude(in_beat.weights[i]);
      end
      if (in_beat.last) begin
        dec_bias <= in_bias;
      end
    end
  end

  assign dec = '{lanes: ops_q, first: first_q, last: last_q, valid: vld_q};

  // Flags of an accepted beat must be known, else lanes load or add garbage
  a_flags_known: assert property (@(posedge clk) disable iff (!rstn)
    in_valid |-> !$isunknown({in_beat.first, in_beat.last}));

endmodule

/* rtl/fc_beat_pkg.sv */
/*
  Beat and lane records passed between the decode, execute and result steps.
  The lane count is fixed here, since packed struct fields need a constant.
*/
package fc_beat_pkg;

  import fc_num_pkg::*;

  localparam int LANES = 4;

  // One input beat. One feature is broadcast to all lanes, with one weight per lane
  typedef struct packed {
    act_t                   feature;
    weight_t [LANES-1:0]    weights;
    logic                   first;
    logic                   last;
  } fc_beat_t;

  // Sign and magnitude operands of one lane multiply
  typedef struct packed {
    logic   sign;
    mag_t   a_mag;
    mag_t   b_mag;
  } lane_op_t;

  typedef struct packed {
    lane_op_t [LANES-1:0]   lanes;
    logic                   first;
    logic                   last;
    logic                   valid;
  } dec_beat_t;

  // Biases use the weight byte format
  typedef weight_t [LANES-1:0] bias_vec_t;

endpackage

/* rtl/fc_core.sv */
`timescale 1ns/1ps
/*
  FC layer core with four lanes. out_valid follows a last beat by 11 cycles.
  There is no back-pressure, so results must be taken when they appear.
*/
module fc_core #(
  parameter int IDX_W = $clog2(fc_beat_pkg::LANES)
) (
  input  logic                                        clk,
  input  logic                                        rstn,
  input  logic                                        in_valid,
  input  fc_beat_pkg::fc_beat_t                       in_beat,
  input  fc_beat_pkg::bias_vec_t                      in_bias,
  output logic                                        out_valid,
  output fc_num_pkg::qout_t [fc_beat_pkg::LANES-1:0]  out_q,
  output logic [IDX_W-1:0]                            out_idx
);
  import fc_num_pkg::*;
  import fc_beat_pkg::*;

  dec_beat_t          dec;
  bias_vec_t          dec_bias;
  logic               acc_valid;
  acc_t [LANES-1:0]   acc;
  bias_vec_t          acc_bias;

  fc_beat_decode u_decode (
    .clk      (clk),
    .rstn     (rstn),
    .in_valid (in_valid),
    .in_beat  (in_beat),
    .in_bias  (in_bias),
    .dec      (dec),
    .dec_bias (dec_bias)
  );

  fc_mac_array u_execute (
    .clk       (clk),
    .rstn      (rstn),
    .dec       (dec),
    .dec_bias  (dec_bias),
    .acc_valid (acc_valid),
    .acc       (acc),
    .acc_bias  (acc_bias)
  );

  fc_result #(
    .IDX_W (IDX_W)
  ) u_result (
    .clk       (clk),
    .rstn      (rstn),
    .acc_valid (acc_valid),
    .acc       (acc),
    .acc_bias  (acc_bias),
    .out_valid (out_valid),
    .out_q     (out_q),
    .out_idx   (out_idx)
  );

endmodule

/* rtl/fc_mac_array.sv */
`timescale 1ns/1ps
/*
  Four multiply-accumulate lanes fed by one decoded beat.
  acc_valid marks the cycle where a vector's last beat has reached the sums.
*/
module fc_mac_array (
  input  logic                                      clk,
  input  logic                                      rstn,
  input  fc_beat_pkg::dec_beat_t                    dec,
  input  fc_beat_pkg::bias_vec_t                    dec_bias,
  output logic                                      acc_valid,
  output fc_num_pkg::acc_t [fc_beat_pkg::LANES-1:0] acc,
  output fc_beat_pkg::bias_vec_t                    acc_bias
);
  import fc_num_pkg::*;
  import fc_beat_pkg::*;

  // Lane pipeline plus the accumulator register
  localparam int DEPTH = MUL_STAGES + 1;

  logic [DEPTH-1:0]   last_pipe;
  bias_vec_t          bias_pipe [DEPTH];

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    mac_lane u_lane (
      .clk      (clk),
      .rstn     (rstn),
      .op_valid (dec.valid),
      .op       (dec.lanes[i]),
      .first    (dec.first),
      .acc      (acc[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Side band delay line
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      last_pipe <= '0;
    end else begin
      last_pipe <= {last_pipe[DEPTH-2:0], dec.valid & dec.last};
    end
  end

  // dec_bias only changes on last beats, so the tap lines up with the vector end
  always_ff @(posedge clk) begin
    bias_pipe[0] <= dec_bias;
    for (int k = 1; k < DEPTH; k++) begin
      bias_pipe[k] <= bias_pipe[k-1];
    end
  end

  assign acc_valid = last_pipe[DEPTH-1];
  assign acc_bias  = bias_pipe[DEPTH-1];

endmodule

/* rtl/fc_num_pkg.sv */
/*
  Numeric formats of the FC core. Features, weights and biases are signed bytes.
  The accumulator is 28 bits wide. Quantized outputs are 7 bits wide in a byte.
*/
package fc_num_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int ACC_W = 28;

  // Lowest accumulator bit kept by the requantizer
  localparam int QUANT_SHIFT = 6;

  // Saturation level after ReLU
  localparam int QUANT_MAX = 127;

  // Lane pipeline registers in front of the accumulator
  localparam int MUL_STAGES = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [7:0] act_t;
  typedef logic signed [7:0] weight_t;

  // Magnitude of a signed byte, so -128 maps to 128
  typedef logic [7:0] mag_t;

  // Magnitude product is at most 2**14, so the signed product fits in 16 bits
  typedef logic signed [15:0] prod_t;

  typedef logic signed [ACC_W-1:0] acc_t;

  typedef logic [7:0] qout_t;

endpackage

/* rtl/fc_result.sv */
`timescale 1ns/1ps
/*
  Bias add, ReLU requantization and argmax in two register stages.
  Sums are taken at the edge that ends acc_valid, before the next vector lands.
*/
module fc_result #(
  parameter int IDX_W = 2
) (
  input  logic                                        clk,
  input  logic                                        rstn,
  input  logic                                        acc_valid,
  input  fc_num_pkg::acc_t  [fc_beat_pkg::LANES-1:0]  acc,
  input  fc_beat_pkg::bias_vec_t                      acc_bias,
  output logic                                        out_valid,
  output fc_num_pkg::qout_t [fc_beat_pkg::LANES-1:0]  out_q,
  output logic [IDX_W-1:0]                            out_idx
);
  import fc_num_pkg::*;
  import fc_beat_pkg::*;

  // Output bits kept below the saturation level
  localparam int KEEP_W = $clog2(QUANT_MAX + 1);

  logic                 sum_valid;
  acc_t  [LANES-1:0]    sum_q;
  qout_t [LANES-1:0]    q_next;
  qout_t                best;
  logic [IDX_W-1:0]     idx_next;

  // Negative gives zero and anything above the kept window saturates
  function automatic qout_t requant(acc_t s);
    if (s[ACC_W-1]) begin
      return '0;
    end
    if (|s[ACC_W-2:QUANT_SHIFT+KEEP_W]) begin
      return qout_t'(QUANT_MAX);
    end
    return qout_t'(s[QUANT_SHIFT+KEEP_W-1:QUANT_SHIFT]);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stage one adds the biases
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= acc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid) begin
      for (int i = 0; i < LANES; i++) begin
        sum_q[i] <= acc[i] + acc_bias[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage two quantizes and picks the index
  ////////////////////////////////////////////////////////////////////////////

  // Strict compare keeps the lowest index on a tie
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      q_next[i] = requant(sum_q[i]);
    end
    best     = q_next[0];
    idx_next = '0;
    for (int i = 1; i < LANES; i++) begin
      if (q_next[i] > best) begin
        best     = q_next[i];
        idx_next = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sum_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      out_q   <= q_next;
      out_idx <= idx_next;
    end
  end

  // A vector end needs known sums and biases, which a missing first beat leaves as X
  a_sums_known: assert property (@(posedge clk) disable iff (!rstn)
    acc_valid |-> !$isunknown({acc, acc_bias}));

endmodule

/* rtl/mac_lane.sv */
`timescale 1ns/1ps
/*
  Sign and magnitude multiplier with a 28-bit accumulator. A beat reaches the
  accumulator MUL_STAGES cycles after the edge that captures op. No stall.
*/
module mac_lane (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    op_valid,
  input  fc_beat_pkg::lane_op_t   op,
  input  logic                    first,
  output fc_num_pkg::acc_t        acc
);
  import fc_num_pkg::*;

  logic [MUL_STAGES-1:0]  vld_pipe;
  logic [MUL_STAGES-1:0]  first_pipe;
  logic [MUL_STAGES-2:0]  sign_pipe;

  mag_t         pp_q   [8];
  logic [5:0]   lo2_q  [4];
  logic [2:0]   hi2a_q [4];
  logic [3:0]   hi2b_q [4];
  logic [9:0]   sum3_q [4];
  logic [7:0]   lo4_q  [2];
  logic [2:0]   hi4a_q [2];
  logic [4:0]   hi4b_q [2];
  logic [11:0]  sum5_q [2];
  logic [9:0]   lo6_q;
  logic [2:0]   hi6a_q;
  logic [6:0]   hi6b_q;
  logic [16:0]  mag7_q;
  prod_t        prod_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[MUL_STAGES-2:0], op_valid};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Magnitude tree
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    first_pipe <= {first_pipe[MUL_STAGES-2:0], first};
    sign_pipe  <= {sign_pipe[MUL_STAGES-3:0], op.sign};

    // Row k is the multiplicand weighted by 2**k
    for (int k = 0; k < 8; k++) begin
      pp_q[k] <= op.b_mag[k] ? op.a_mag : '0;
    end

    // Row pairs add their low bits first and the upper bits one cycle later
    for (int k = 0; k < 4; k++) begin
      lo2_q[k]  <= pp_q[2*k][4:0] + {pp_q[2*k+1][3:0], 1'b0};
      hi2a_q[k] <= pp_q[2*k][7:5];
      hi2b_q[k] <= pp_q[2*k+1][7:4];
    end
    for (int k = 0; k < 4; k++) begin
      sum3_q[k] <= {5'(hi2a_q[k] + hi2b_q[k] + lo2_q[k][5]), lo2_q[k][4:0]};
    end

    // Pairs of pairs are offset by two bits
    for (int j = 0; j < 2; j++) begin
      lo4_q[j]  <= sum3_q[2*j][6:0] + {sum3_q[2*j+1][4:0], 2'b0};
      hi4a_q[j] <= sum3_q[2*j][9:7];
      hi4b_q[j] <= sum3_q[2*j+1][9:5];
    end
    for (int j = 0; j < 2; j++) begin
      sum5_q[j] <= {5'(hi4a_q[j] + hi4b_q[j] + lo4_q[j][7]), lo4_q[j][6:0]};
    end

    // Final halves are offset by four bits
    lo6_q  <= sum5_q[0][8:0] + {sum5_q[1][4:0], 4'b0};
    hi6a_q <= sum5_q[0][11:9];
    hi6b_q <= sum5_q[1][11:5];
    mag7_q <= {8'(hi6a_q + hi6b_q + lo6_q[9]), lo6_q[8:0]};

    // Sign applied by two's complement
    prod_q <= sign_pipe[MUL_STAGES-2] ? prod_t'(~mag7_q[15:0] + 16'd1)
                                      : prod_t'(mag7_q[15:0]);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////////////////////////////////////////

  // The first beat of a vector loads and the rest add
  always_ff @(posedge clk) begin
    if (vld_pipe[MUL_STAGES-1]) begin
      if (first_pipe[MUL_STAGES-1]) begin
        acc <= acc_t'(prod_q);
      end else begin
        acc <= acc + prod_q;
      end
    end
  end

  // 128 x 128 is the largest magnitude product, so the tree never exceeds 2**14
  a_mag_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
    vld_pipe[MUL_STAGES-2] |-> mag7_q <= 17'd16384);

endmodule

/* include/fc_ref_model.svh */
/*
  Reference functions for checking the FC core. Sums are exact, so vectors
  must stay short enough that a lane never leaves the 28-bit range.
*/
`ifndef FC_REF_MODEL_SVH
`define FC_REF_MODEL_SVH

// Exact signed product of one feature and one weight
function automatic int ref_product(fc_num_pkg::act_t f, fc_num_pkg::weight_t w);
  return int'(f) * int'(w);
endfunction

// ReLU, then saturation at 2**13 and the shift down to the kept bits
function automatic fc_num_pkg::qout_t ref_requant(longint sum);
  longint lim;
  lim = longint'(fc_num_pkg::QUANT_MAX + 1) << fc_num_pkg::QUANT_SHIFT;
  if (sum < 0) begin
    return '0;
  end
  if (sum >= lim) begin
    return fc_num_pkg::qout_t'(fc_num_pkg::QUANT_MAX);
  end
  return fc_num_pkg::qout_t'(sum >>> fc_num_pkg::QUANT_SHIFT);
endfunction

// Dot product of one lane plus its bias, quantized
function automatic fc_num_pkg::qout_t ref_lane(longint dot, fc_num_pkg::weight_t bias);
  return ref_requant(dot + longint'(bias));
endfunction

// Lowest index wins a tie
function automatic int ref_argmax(fc_num_pkg::qout_t [fc_beat_pkg::LANES-1:0] q);
  int best;
  best = 0;
  for (int i = 1; i < fc_beat_pkg::LANES; i++) begin
    if (q[i] > q[best]) begin
      best = i;
    end
  end
  return best;
endfunction

`endif

/* sim/fc_core_tb.sv */
`timescale 1ns/1ps
/*
  Self-checking testbench for the FC core with random vectors of 1 to 16 beats.
  Sums of 16 beats stay far inside 28 bits, so the exact model matches the lanes.
*/
module fc_core_tb;
  import fc_num_pkg::*;
  import fc_beat_pkg::*;

  `include "fc_ref_model.svh"

  localparam int IDX_W     = $clog2(LANES);
  localparam int MAX_LEN   = 16;
  localparam int LATENCY   = 11;
  localparam int N_SINGLE  = 40;
  localparam int N_B2B     = 60;
  localparam int N_EXTREME = 8;
  localparam int N_TIE     = 12;
  localparam int N_GAPS    = 80;
  localparam int N_VECTORS = N_SINGLE + N_B2B + N_EXTREME + N_TIE + N_GAPS;

  // Worst case per vector is 16 beats with 3 idle cycles each plus the pipeline
  localparam longint WATCHDOG_NS = longint'(N_VECTORS) * (MAX_LEN * 4 + LATENCY) * 20 * 2;

  localparam int KIND_RANDOM = 0;
  localparam int KIND_SAT    = 1;
  localparam int KIND_NEG    = 2;
  localparam int KIND_TIE    = 3;

  // Expected result of one vector and the cycle it must show up in
  typedef struct packed {
    logic [31:0]          cycle;
    qout_t [LANES-1:0]    q;
    logic [IDX_W-1:0]     idx;
  } expect_t;

  logic                 clk = 1'b0;
  logic                 rstn;
  logic                 in_valid;
  fc_beat_t             in_beat;
  bias_vec_t            in_bias;
  logic                 out_valid;
  qout_t [LANES-1:0]    out_q;
  logic [IDX_W-1:0]     out_idx;

  expect_t  exp_q [$];
  int       cyc = 0;
  int       errors = 0;
  int       pulses = 0;
  int       sent = 0;
  int       tests = 0;
  int       failed_tests = 0;
  string    test_name = "reset";

  fc_core #(
    .IDX_W (IDX_W)
  ) uut (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_bias   (in_bias),
    .out_valid (out_valid),
    .out_q     (out_q),
    .out_idx   (out_idx)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic compare(string what, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard samples on the falling edge where outputs are stable
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    expect_t e;
    if (rstn && out_valid) begin
      pulses++;
      if (exp_q.size() == 0) begin
        $display("Unexpected out_valid in test %s at cycle %0d, no vector pending",
                 test_name, cyc);
        errors++;
      end else begin
        e = exp_q.pop_front();
        compare("latency", e.cycle, cyc);
        for (int i = 0; i < LANES; i++) begin
          compare($sformatf("out_q[%0d]", i), 32'(e.q[i]), 32'(out_q[i]));
        end
        compare("out_idx", 32'(e.idx), 32'(out_idx));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Idle cycle with junk on the data and flags that the DUT must ignore
  task automatic drive_idle();
    @(negedge clk);
    in_valid        = 1'b0;
    in_beat.feature = act_t'($urandom);
    for (int i = 0; i < LANES; i++) begin
      in_beat.weights[i] = weight_t'($urandom);
    end
    in_beat.first = 1'($urandom);
    in_beat.last  = 1'($urandom);
    in_bias       = bias_vec_t'($urandom);
  endtask

  task automatic send_vector(int len, int max_gap, int kind);
    longint     dot [LANES];
    act_t       f;
    weight_t    w [LANES];
    weight_t    shared;
    bias_vec_t  bias;
    expect_t    e;
    int         gap;
    for (int i = 0; i < LANES; i++) begin
      dot[i] = 0;
    end
    bias = bias_vec_t'($urandom);
    if (kind == KIND_TIE) begin
      shared = weight_t'($urandom);
      for (int i = 0; i < LANES; i++) begin
        bias[i] = shared;
      end
    end
    for (int b = 0; b < len; b++) begin
      case (kind)
        KIND_SAT: begin
          f = -8'sd128;
          for (int i = 0; i < LANES; i++) w[i] = -8'sd128;
        end
        KIND_NEG: begin
          f = -8'sd128;
          for (int i = 0; i < LANES; i++) w[i] = 8'sd127;
        end
        KIND_TIE: begin
          f      = act_t'($urandom);
          shared = weight_t'($urandom);
          for (int i = 0; i < LANES; i++) w[i] = shared;
        end
        default: begin
          f = act_t'($urandom);
          for (int i = 0; i < LANES; i++) w[i] = weight_t'($urandom);
        end
      endcase
      @(negedge clk);
      in_valid        = 1'b1;
      in_beat.feature = f;
      for (int i = 0; i < LANES; i++) begin
        in_beat.weights[i] = w[i];
        dot[i] += longint'(ref_product(f, w[i]));
      end
      in_beat.first = (b == 0);
      in_beat.last  = (b == len - 1);
      // Earlier beats carry junk in place of the bias
      in_bias = (b == len - 1) ? bias : bias_vec_t'($urandom);
      if (b == len - 1) begin
        for (int i = 0; i < LANES; i++) begin
          e.q[i] = ref_lane(dot[i], bias[i]);
        end
        e.idx   = IDX_W'(ref_argmax(e.q));
        e.cycle = 32'(cyc + LATENCY + 1);
        exp_q.push_back(e);
        sent++;
      end
      gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
      repeat (gap) drive_idle();
    end
  endtask

  // Waits for the pending results within a bound well above the pipeline latency
  task automatic end_test(int err_at_start);
    int waited;
    waited = 0;
    drive_idle();
    while (exp_q.size() != 0 && waited < 4 * LATENCY) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Test %s: %0d results never appeared", test_name, exp_q.size());
      errors += exp_q.size();
      exp_q.delete();
    end
    tests++;
    if (errors != err_at_start) begin
      failed_tests++;
    end
    $display("Test %-12s done, %0d errors", test_name, errors - err_at_start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_tests();
    int e0;
    test_name = "reset_idle";
    e0 = errors;
    repeat (20) begin
      @(negedge clk);
      compare("out_valid", 32'd0, 32'(out_valid));
    end
    end_test(e0);

    test_name = "single_beat";
    e0 = errors;
    for (int n = 0; n < N_SINGLE; n++) send_vector(1, 3, KIND_RANDOM);
    end_test(e0);

    test_name = "back_to_back";
    e0 = errors;
    for (int n = 0; n < N_B2B; n++) send_vector($urandom_range(MAX_LEN, 1), 0, KIND_RANDOM);
    end_test(e0);

    // Saturating sums come first and clearly negative sums follow
    test_name = "extreme";
    e0 = errors;
    for (int n = 0; n < N_EXTREME / 2; n++) send_vector(MAX_LEN, 1, KIND_SAT);
    for (int n = 0; n < N_EXTREME / 2; n++) send_vector(MAX_LEN, 1, KIND_NEG);
    end_test(e0);

    test_name = "argmax_ties";
    e0 = errors;
    for (int n = 0; n < N_TIE; n++) send_vector($urandom_range(MAX_LEN, 1), 3, KIND_TIE);
    end_test(e0);

    test_name = "random_gaps";
    e0 = errors;
    for (int n = 0; n < N_GAPS; n++) send_vector($urandom_range(MAX_LEN, 1), 3, KIND_RANDOM);
    end_test(e0);

    test_name = "pulse_count";
    e0 = errors;
    compare("pulses", 32'(sent), 32'(pulses));
    end_test(e0);
  endtask

  initial begin
    void'($urandom(32'h5d42));
    rstn     = 1'b0;
    in_valid = 1'b0;
    in_beat  = '0;
    in_bias  = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    run_tests();
    $display("%0d tests, %0d failed, %0d vectors, %0d pulses, %0d errors",
             tests, failed_tests, sent, pulses, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns during test %s", WATCHDOG_NS, test_name);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
